// File: uart.f
logic/uart_frame_pkg.sv
logic/uart_ctrl_pkg.sv
logic/uart_cmd_tx.sv
logic/uart_byte_rx.sv
logic/uart.sv
sim/uart_checker.sv
sim/uart_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = uart_tb
FILELIST  = uart.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

// File: sim/uart_tb.sv
`default_nettype none

module uart_tb
   import uart_frame_pkg::*;
();

   logic                 clk = 1'b0;
   logic                 rst_n;
   logic [cmd_bits-1:0]  cmd_in;
   logic                 cmd_vld;
   logic                 rx;
   wire                  tx;
   wire                  cmd_rdy;
   wire [data_bits-1:0]  read_data;
   wire                  read_rdy;
   wire                  rx_err;
   logic                 tx_exp_vld;
   logic [cmd_bits-1:0]  tx_exp_cmd;
   logic                 rx_exp_vld;
   logic                 rx_exp_err;
   logic [data_bits-1:0] rx_exp_byte;
   int                   errors;
   int                   tx_frames;
   int                   rx_pulses;
   integer               seed;
   logic [31:0]          r;
   int                   tests_run;
   int                   tests_failed;
   int                   errs_before;
   int                   n_tx;           // commands sent
   int                   n_rx;           // frames sent on rx

   always #2 clk = ~clk;

   uart u_dut (
      .clk(clk), .rst_n(rst_n), .cmd_in(cmd_in), .cmd_vld(cmd_vld), .rx(rx),
      .tx(tx), .cmd_rdy(cmd_rdy), .read_data(read_data), .read_rdy(read_rdy), .rx_err(rx_err)
   );

   uart_checker u_chk (
      .clk(clk), .rst_n(rst_n), .tx(tx), .cmd_rdy(cmd_rdy), .read_data(read_data),
      .read_rdy(read_rdy), .rx_err(rx_err), .tx_exp_vld(tx_exp_vld), .tx_exp_cmd(tx_exp_cmd),
      .rx_exp_vld(rx_exp_vld), .rx_exp_err(rx_exp_err), .rx_exp_byte(rx_exp_byte),
      .errors(errors), .tx_frames(tx_frames), .rx_pulses(rx_pulses)
   );

   task automatic finish_run();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   endtask

   task automatic abort(input string what);
      $display("timeout at %0t: %s", $time, what);
      tests_run++;
      tests_failed++;
      finish_run();
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != errs_before) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errs_before);
      end else begin
         $display("test %s: ok", name);
      end
      errs_before = errors;
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_cmd_rdy();
      int t;
      t = 0;
      while (!cmd_rdy && t < 200) begin
         @(negedge clk);
         t++;
      end
      if (!cmd_rdy) abort("cmd_rdy never came back high");
   endtask

   task automatic wait_tx_done();
      int t;
      t = 0;
      while (tx_frames < n_tx && t < 300) begin
         @(negedge clk);
         t++;
      end
      if (tx_frames < n_tx) abort("the tx frame pair did not finish");
   endtask

   task automatic wait_rx_done();
      int t;
      t = 0;
      while (rx_pulses < n_rx && t < 200) begin
         @(negedge clk);
         t++;
      end
      if (rx_pulses < n_rx) abort("no read_rdy or rx_err pulse arrived for a frame");
   endtask

   task automatic send_cmd(input logic [cmd_bits-1:0] cmd);
      wait_cmd_rdy();
      cmd_in     = cmd;
      cmd_vld    = 1'b1;
      tx_exp_cmd = cmd;
      tx_exp_vld = 1'b1;
      @(negedge clk);
      cmd_vld    = 1'b0;
      tx_exp_vld = 1'b0;
      n_tx++;
   endtask

   // one frame on rx, optionally with bad parity or a low stop bit
   task automatic send_byte(input logic [data_bits-1:0] b, input logic bad_par,
                            input logic bad_stop);
      logic [frame_bits-1:0] frame;
      int                    ones;
      ones = 0;
      for (int i = 0; i < data_bits; i++) begin
         ones += b[i];
      end
      frame = {1'b0, b, (ones % 2 == 0) ^ bad_par, ~bad_stop};
      rx_exp_byte = b;
      rx_exp_err  = bad_par | bad_stop;
      rx_exp_vld  = 1'b1;
      for (int i = frame_bits - 1; i >= 0; i--) begin
         rx = frame[i];
         repeat (clks_per_bit) begin
            @(negedge clk);
            rx_exp_vld = 1'b0;
         end
      end
      n_rx++;
   endtask

   initial begin
      seed = 32'h6969;
      rst_n = 1'b0;
      cmd_in = '0;
      cmd_vld = 1'b0;
      rx = 1'b1;
      tx_exp_vld = 1'b0;
      tx_exp_cmd = '0;
      rx_exp_vld = 1'b0;
      rx_exp_err = 1'b0;
      rx_exp_byte = '0;
      tests_run = 0;
      tests_failed = 0;
      errs_before = 0;
      n_tx = 0;
      n_rx = 0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      idle(4);
      end_test("reset values");

      for (int i = 0; i < 20; i++) begin
         r = $random(seed);
         send_cmd(r[cmd_bits-1:0]);
      end
      wait_tx_done();
      end_test("random commands");

      r = $random(seed);
      send_cmd(r[cmd_bits-1:0]);
      idle(20);
      cmd_in  = ~r[cmd_bits-1:0];   // must be ignored, cmd_rdy is low
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      wait_tx_done();
      r = $random(seed);
      send_cmd(r[cmd_bits-1:0]);
      wait_tx_done();
      end_test("cmd_vld while busy");

      for (int i = 0; i < 20; i++) begin
         r = $random(seed);
         send_byte(r[data_bits-1:0], 1'b0, 1'b0);
         if (i % 4 == 3) idle(6);   // others go back to back
      end
      wait_rx_done();
      end_test("good rx frames");

      for (int i = 0; i < 4; i++) begin
         r = $random(seed);
         send_byte(r[data_bits-1:0], (i % 2 == 0), (i % 2 == 1));
         rx = 1'b1;
         idle(2 * clks_per_bit);
      end
      wait_rx_done();
      end_test("bad parity and stop");

      rx = 1'b0;
      @(negedge clk);   // shorter than half_bit
      rx = 1'b1;
      idle(8);
      r = $random(seed);
      send_byte(r[data_bits-1:0], 1'b0, 1'b0);
      wait_rx_done();
      idle(20);
      end_test("rx glitch");

      finish_run();
   end

endmodule

`default_nettype wire

// File: sim/uart_checker.sv
`default_nettype none

module uart_checker
   import uart_frame_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  tx,
   input  wire                  cmd_rdy,
   input  wire [data_bits-1:0]  read_data,
   input  wire                  read_rdy,
   input  wire                  rx_err,
   input  wire                  tx_exp_vld,   // testbench queues a command it sent
   input  wire [cmd_bits-1:0]   tx_exp_cmd,
   input  wire                  rx_exp_vld,   // testbench queues a frame it put on rx
   input  wire                  rx_exp_err,
   input  wire [data_bits-1:0]  rx_exp_byte,
   output int                   errors,
   output int                   tx_frames,
   output int                   rx_pulses
);

   logic [cmd_bits-1:0]  tx_exp[$];
   logic [data_bits:0]   rx_exp[$];           // {error expected, byte}
   logic [data_bits-1:0] last_good = '0;
   logic                 reset_seen = 1'b0;
   logic                 tx_prev;
   int                   cycle = 0;           // rising edges so far
   int                   acc_cycle = -1;      // edge where the last command was taken

   // start 0, byte msb first, odd parity, stop 1, high byte first
   function automatic logic [pair_bits-1:0] frame_pair(input logic [cmd_bits-1:0] cmd);
      logic [pair_bits-1:0] bits;
      logic [data_bits-1:0] b;
      int                   ones;
      int                   pos;
      bits = '0;
      pos  = pair_bits - 1;
      for (int f = 0; f < frames_per_cmd; f++) begin
         b    = cmd[cmd_bits-1-f*data_bits -: data_bits];
         ones = 0;
         bits[pos] = 1'b0;
         pos--;
         for (int i = data_bits - 1; i >= 0; i--) begin
            bits[pos] = b[i];
            ones += b[i];
            pos--;
         end
         bits[pos] = (ones % 2 == 0);   // makes the total count odd
         pos--;
         bits[pos] = 1'b1;
         pos--;
      end
      return bits;
   endfunction

   task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      errors++;
   endtask

   // entered on the first negedge with tx low
   task automatic check_tx_pair();
      logic [cmd_bits-1:0]  cmd;
      logic [pair_bits-1:0] exp_bits;
      int                   bit_idx;
      cmd     = '0;
      bit_idx = 0;
      if (tx_exp.size() == 0) begin
         $display("tx started a frame at time %0t with no command sent", $time);
         errors++;
      end else begin
         cmd = tx_exp.pop_front();
      end
      if (cycle - acc_cycle != 1) begin
         report("tx start delay", 1, cycle - acc_cycle);
      end
      exp_bits = frame_pair(cmd);
      for (int off = 0; off < pair_bits * clks_per_bit; off++) begin
         if (off % clks_per_bit == half_bit) begin
            bit_idx = pair_bits - 1 - off / clks_per_bit;
            if (tx !== exp_bits[bit_idx]) begin
               report("tx", exp_bits[bit_idx], tx);
            end
         end
         if (cmd_rdy !== 1'b0) begin
            report("cmd_rdy", 0, cmd_rdy);
         end
         @(negedge clk);
      end
      // last stop bit ended on the previous rising edge
      if (cmd_rdy !== 1'b1) begin
         report("cmd_rdy", 1, cmd_rdy);
      end
      tx_frames++;
   endtask

   initial begin
      errors    = 0;
      tx_frames = 0;
      rx_pulses = 0;
      tx_prev   = 1'b1;
      forever begin
         @(negedge clk);
         if (rst_n && cycle == acc_cycle && cmd_rdy !== 1'b0) begin
            report("cmd_rdy", 0, cmd_rdy);
         end
         if (rst_n && tx_prev && !tx) begin
            check_tx_pair();
         end
         tx_prev = tx;
      end
   end

   always @(posedge clk) begin
      cycle++;
      if (tx_exp_vld) begin
         tx_exp.push_back(tx_exp_cmd);
         acc_cycle = cycle;
      end
      if (rx_exp_vld) begin
         rx_exp.push_back({rx_exp_err, rx_exp_byte});
      end
   end

   always @(negedge clk) begin
      logic [data_bits:0] exp;
      if (rst_n && !reset_seen) begin
         reset_seen = 1'b1;
         if (tx !== 1'b1) report("tx", 1, tx);
         if (cmd_rdy !== 1'b1) report("cmd_rdy", 1, cmd_rdy);
         if (read_rdy !== 1'b0) report("read_rdy", 0, read_rdy);
         if (rx_err !== 1'b0) report("rx_err", 0, rx_err);
         if (read_data !== '0) report("read_data", 0, read_data);
      end
      if (rst_n && (read_rdy || rx_err)) begin
         rx_pulses++;
         if (rx_exp.size() == 0) begin
            $display("receive pulse at time %0t with no frame sent on rx", $time);
            errors++;
         end else begin
            exp = rx_exp.pop_front();
            if (exp[data_bits]) begin
               if (rx_err !== 1'b1) report("rx_err", 1, rx_err);
               if (read_rdy !== 1'b0) report("read_rdy", 0, read_rdy);
            end else begin
               if (read_rdy !== 1'b1) report("read_rdy", 1, read_rdy);
               if (rx_err !== 1'b0) report("rx_err", 0, rx_err);
               last_good = exp[data_bits-1:0];
            end
            if (read_data !== last_good) report("read_data", last_good, read_data);
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/uart.sv
`default_nettype none

module uart
   import uart_frame_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire [cmd_bits-1:0]   cmd_in,
   input  wire                  cmd_vld,
   input  wire                  rx,
   output logic                 tx,
   output logic                 cmd_rdy,
   output logic [data_bits-1:0] read_data,
   output logic                 read_rdy,
   output logic                 rx_err
);

   // command in, two frames out on tx
   uart_cmd_tx u_cmd_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .tx      (tx),
      .cmd_rdy (cmd_rdy)
   );

   // frames in on rx, one byte per frame
   uart_byte_rx u_byte_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .rx_err    (rx_err)
   );

endmodule

`default_nettype wire

// File: logic/uart_byte_rx.sv
`default_nettype none

module uart_byte_rx
   import uart_frame_pkg::*, uart_ctrl_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  rx,
   output logic [data_bits-1:0] read_data,
   output logic                 read_rdy,
   output logic                 rx_err
);

   logic                    rx_meta;
   logic                    rx_sync;
   rx_state_t               state;
   logic [clk_cnt_w-1:0]    clk_cnt;
   logic [data_cnt_w-1:0]   bit_cnt;    // data bits taken so far
   logic [data_bits-1:0]    shift;
   logic                    par_bit;
   logic                    half_done;  // middle of the start bit
   logic                    mid_bit;    // middle of data, parity and stop bits
   logic                    frame_ok;

   // two flops on the asynchronous line, idle high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   assign half_done = clk_cnt == clk_cnt_w'(half_bit - 1);
   assign mid_bit   = clk_cnt == clk_cnt_w'(clks_per_bit - 1);

   // checked at the stop sample, rx_sync is the stop bit itself
   assign frame_ok = (^{shift, par_bit}) & rx_sync;

   // data bits arrive msb first
   always_ff @(posedge clk) begin
      if (mid_bit) begin
         if (state == rx_data) begin
            shift <= {shift[data_bits-2:0], rx_sync};
         end
         if (state == rx_parity) begin
            par_bit <= rx_sync;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= rx_idle;
         clk_cnt   <= '0;
         bit_cnt   <= '0;
         read_data <= '0;
         read_rdy  <= 1'b0;
         rx_err    <= 1'b0;
      end else begin
         read_rdy <= 1'b0;    // pulses last one cycle
         rx_err   <= 1'b0;
         case (state)
            rx_idle: begin
               clk_cnt <= '0;
               if (!rx_sync) begin
                  state <= rx_start;
               end
            end

            rx_start: begin
               if (half_done) begin
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= rx_sync ? rx_idle : rx_data;    // high again: glitch
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            rx_data: begin
               if (mid_bit) begin
                  clk_cnt <= '0;
                  if (bit_cnt == data_cnt_w'(data_bits - 1)) begin
                     state <= rx_parity;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            rx_parity: begin
               if (mid_bit) begin
                  clk_cnt <= '0;
                  state   <= rx_stop;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            rx_stop: begin
               if (mid_bit) begin
                  clk_cnt <= '0;
                  state   <= rx_idle;    // next start edge may follow at once
                  if (frame_ok) begin
                     read_data <= shift;
                     read_rdy  <= 1'b1;
                  end else begin
                     rx_err <= 1'b1;    // bad parity or stop bit low
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            default: begin
               state <= rx_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/uart_cmd_tx.sv
`default_nettype none

module uart_cmd_tx
   import uart_frame_pkg::*, uart_ctrl_pkg::*;
(
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire [cmd_bits-1:0]  cmd_in,
   input  wire                 cmd_vld,
   output logic                tx,
   output logic                cmd_rdy
);

   tx_state_t               state;
   logic [clk_cnt_w-1:0]    clk_cnt;    // cycles inside the current bit
   logic [pair_cnt_w-1:0]   bit_cnt;    // bits already started
   logic [pair_bits-1:0]    shreg;
   logic [data_bits-1:0]    byte_hi;
   logic [data_bits-1:0]    byte_lo;
   logic                    par_hi;
   logic                    par_lo;
   logic [frame_bits-1:0]   frame_hi;
   logic [frame_bits-1:0]   frame_lo;
   logic                    accept;
   logic                    bit_start;  // first cycle of a bit time
   logic                    bit_end;    // last cycle of a bit time

   assign byte_hi = cmd_in[cmd_bits-1 -: data_bits];
   assign byte_lo = cmd_in[data_bits-1:0];

   // odd parity: ones over data plus parity come out odd
   assign par_hi = ~^byte_hi;
   assign par_lo = ~^byte_lo;

   assign frame_hi = {1'b0, byte_hi, par_hi, 1'b1};
   assign frame_lo = {1'b0, byte_lo, par_lo, 1'b1};

   assign accept    = cmd_vld & cmd_rdy;
   assign bit_start = (state == tx_shift) && (clk_cnt == '0);
   assign bit_end   = clk_cnt == clk_cnt_w'(clks_per_bit - 1);

   // frame pair, msb leaves first
   always_ff @(posedge clk) begin
      if (accept) begin
         shreg <= {frame_hi, frame_lo};
      end else if (bit_start) begin
         shreg <= {shreg[pair_bits-2:0], 1'b1};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= tx_idle;
         clk_cnt <= '0;
         bit_cnt <= '0;
         tx      <= 1'b1;    // line idles high
         cmd_rdy <= 1'b1;
      end else begin
         case (state)
            tx_idle: begin
               if (accept) begin
                  cmd_rdy <= 1'b0;
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= tx_shift;
               end
            end

            tx_shift: begin
               if (bit_start) begin
                  tx <= shreg[pair_bits-1];
               end
               if (bit_end) begin
                  clk_cnt <= '0;
                  if (bit_cnt == pair_cnt_w'(pair_bits - 1)) begin
                     bit_cnt <= '0;
                     state   <= tx_done;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            // second stop bit has been held for its full time here,
            // tx stays high
            tx_done: begin
               cmd_rdy <= 1'b1;
               state   <= tx_idle;
            end

            default: begin
               state <= tx_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/uart_ctrl_pkg.sv
`default_nettype none

package uart_ctrl_pkg;

   typedef enum logic [1:0] {
      tx_idle,     // waiting for a command
      tx_shift,    // both frames going out
      tx_done      // last stop bit finished
   } tx_state_t;

   typedef enum logic [2:0] {
      rx_idle,     // line high, looking for a start bit
      rx_start,    // start edge seen, waiting for mid-bit
      rx_data,
      rx_parity,
      rx_stop
   } rx_state_t;

endpackage

`default_nettype wire

// File: logic/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

   // line format
   localparam int data_bits      = 8;    // payload bits per frame
   localparam int frame_bits     = 11;   // start, data, parity, stop
   localparam int frames_per_cmd = 2;    // high byte goes first
   localparam int cmd_bits       = 16;

   // bit timing on the line
   localparam int clks_per_bit   = 4;
   localparam int half_bit       = 2;    // start edge to mid-bit sample

   // derived sizes
   localparam int pair_bits      = frame_bits * frames_per_cmd;
   localparam int clk_cnt_w      = $clog2(clks_per_bit);
   localparam int pair_cnt_w     = $clog2(pair_bits);
   localparam int data_cnt_w     = $clog2(data_bits);

endpackage

`default_nettype wire
